/* hw/normalize_stage.sv */
// Last pipeline stage; divides each scaled ReLU element by its row sum, zero row on zero sum
`timescale 1ns/100ps

module normalize_stage #(
    parameter int DATA_WIDTH = softmax_pkg::DEF_DATA_WIDTH,
    parameter int SEQ_LEN    = softmax_pkg::DEF_SEQ_LEN
)(
    input  logic   clk,
    input  logic   rst_n,
    row_bus_if.dst up,
    row_bus_if.src down
);

    localparam int SUM_WIDTH = DATA_WIDTH + $clog2(SEQ_LEN);
    localparam int NUM_WIDTH = DATA_WIDTH + softmax_pkg::FRAC_SHIFT;
    // Divider operands share one width
    localparam int DIV_WIDTH = (NUM_WIDTH > SUM_WIDTH) ? NUM_WIDTH : SUM_WIDTH;
    // Largest legal weight, one in fixed point
    localparam logic [DATA_WIDTH-1:0] ONE_FX = DATA_WIDTH'(1 << softmax_pkg::FRAC_SHIFT);

    logic [DIV_WIDTH-1:0]  numer   [SEQ_LEN-1:0];
    logic [DIV_WIDTH-1:0]  denom;
    logic [DATA_WIDTH-1:0] quot    [SEQ_LEN-1:0];
    logic                  over_range;

    // ------------------------------
    // Scale and divide
    // ------------------------------
    always_comb begin
        denom = DIV_WIDTH'(up.row_sum);
        for (int j = 0; j < SEQ_LEN; j++) begin
            numer[j] = DIV_WIDTH'(up.elems[j]) << softmax_pkg::FRAC_SHIFT;
            if (up.row_sum == '0) begin
                quot[j] = '0;
            end else begin
                // Element <= sum, so the quotient is at most ONE_FX and fits
                quot[j] = DATA_WIDTH'(numer[j] / denom);
            end
        end
    end

    // ------------------------------
    // Output register
    // ------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            down.valid <= 1'b0;
        end else begin
            down.valid <= up.valid;
        end
    end

    always_ff @(posedge clk) begin
        down.row_idx <= up.row_idx;
        down.row_sum <= up.row_sum;
        for (int j = 0; j < SEQ_LEN; j++) begin
            down.elems[j] <= quot[j];
        end
    end

    always_comb begin
        over_range = 1'b0;
        for (int j = 0; j < SEQ_LEN; j++) begin
            over_range = over_range | (down.elems[j] > ONE_FX);
        end
    end

    // A weight above one means the sum stage and this stage disagree
    a_weight_in_range: assert property (@(posedge clk) disable iff (!rst_n)
        down.valid |-> !over_range);

endmodule

/* hw/relu_stage.sv */
// First pipeline stage; clamps negative scores of a row to zero, one row per cycle
`timescale 1ns/100ps

module relu_stage #(
    parameter int DATA_WIDTH = softmax_pkg::DEF_DATA_WIDTH,
    parameter int SEQ_LEN    = softmax_pkg::DEF_SEQ_LEN
)(
    input  logic   clk,
    input  logic   rst_n,
    row_bus_if.dst up,
    row_bus_if.src down
);

    logic neg_seen;

    // Strobe
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            down.valid <= 1'b0;
        end else begin
            down.valid <= up.valid;
        end
    end

    // ReLU on all elements at once, sign bit selects zero
    always_ff @(posedge clk) begin
        down.row_idx <= up.row_idx;
        for (int j = 0; j < SEQ_LEN; j++) begin
            if (up.elems[j][DATA_WIDTH-1]) begin
                down.elems[j] <= '0;
            end else begin
                down.elems[j] <= up.elems[j];
            end
        end
    end

    // Sum is formed in the next stage
    assign down.row_sum = '0;

    // Any negative element left on the output
    always_comb begin
        neg_seen = 1'b0;
        for (int j = 0; j < SEQ_LEN; j++) begin
            neg_seen = neg_seen | down.elems[j][DATA_WIDTH-1];
        end
    end

    a_no_negative_out: assert property (@(posedge clk) disable iff (!rst_n)
        down.valid |-> !neg_seen);

endmodule

/* hw/row_bus_if.sv */
// Row transfer bus between pipeline stages; instantiate once per hop with src and dst modports
`timescale 1ns/100ps

interface row_bus_if #(
    parameter int DATA_WIDTH = softmax_pkg::DEF_DATA_WIDTH,
    parameter int SEQ_LEN    = softmax_pkg::DEF_SEQ_LEN
);

    // Sum of SEQ_LEN elements needs log2(SEQ_LEN) extra bits
    localparam int SUM_WIDTH = DATA_WIDTH + $clog2(SEQ_LEN);

    // One-cycle strobe per row, no ready
    logic                                  valid;
    logic [softmax_pkg::ROW_IDX_WIDTH-1:0] row_idx;
    logic [DATA_WIDTH-1:0]                 elems [SEQ_LEN-1:0];
    // Only meaningful after the sum stage
    logic [SUM_WIDTH-1:0]                  row_sum;

    modport src (
        output valid,
        output row_idx,
        output elems,
        output row_sum
    );

    modport dst (
        input valid,
        input row_idx,
        input elems,
        input row_sum
    );

endinterface

/* hw/row_sum_stage.sv */
// Second pipeline stage; adds the ReLU elements of a row into a widened sum and forwards both
`timescale 1ns/100ps

module row_sum_stage #(
    parameter int DATA_WIDTH = softmax_pkg::DEF_DATA_WIDTH,
    parameter int SEQ_LEN    = softmax_pkg::DEF_SEQ_LEN
)(
    input  logic   clk,
    input  logic   rst_n,
    row_bus_if.dst up,
    row_bus_if.src down
);

    // log2(SEQ_LEN) guard bits, so the sum cannot wrap
    localparam int SUM_WIDTH = DATA_WIDTH + $clog2(SEQ_LEN);

    logic [SUM_WIDTH-1:0] sum_comb;

    // ------------------------------
    // Adder tree (flat loop)
    // ------------------------------
    always_comb begin
        sum_comb = '0;
        for (int j = 0; j < SEQ_LEN; j++) begin
            // Elements are non-negative here, zero extension is enough
            sum_comb = sum_comb + SUM_WIDTH'(up.elems[j]);
        end
    end

    // ------------------------------
    // Output register
    // ------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            down.valid <= 1'b0;
        end else begin
            down.valid <= up.valid;
        end
    end

    // Values travel on so the divider has them next to the sum
    always_ff @(posedge clk) begin
        down.row_idx <= up.row_idx;
        down.row_sum <= sum_comb;
        for (int j = 0; j < SEQ_LEN; j++) begin
            down.elems[j] <= up.elems[j];
        end
    end

endmodule

/* hw/softmax_approx_top.sv */
// Top level of the row-pipelined softmax approximation; plain matrix ports, start/done pulses
`timescale 1ns/100ps

module softmax_approx_top #(
    parameter int DATA_WIDTH = softmax_pkg::DEF_DATA_WIDTH,
    parameter int SEQ_LEN    = softmax_pkg::DEF_SEQ_LEN,
    parameter int NUM_HEADS  = softmax_pkg::DEF_NUM_HEADS
)(
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  start,
    // Shape (SEQ_LEN, NUM_HEADS, SEQ_LEN), row-major, held stable until done
    input  logic [DATA_WIDTH-1:0] scores_in   [SEQ_LEN*NUM_HEADS*SEQ_LEN-1:0],
    output logic [DATA_WIDTH-1:0] weights_out [SEQ_LEN*NUM_HEADS*SEQ_LEN-1:0],
    output logic                  done,
    output logic                  out_valid
);

    // ------------------------------
    // Row buses, one per hop
    // ------------------------------
    row_bus_if #(.DATA_WIDTH(DATA_WIDTH), .SEQ_LEN(SEQ_LEN)) seq_to_relu  ();
    row_bus_if #(.DATA_WIDTH(DATA_WIDTH), .SEQ_LEN(SEQ_LEN)) relu_to_sum  ();
    row_bus_if #(.DATA_WIDTH(DATA_WIDTH), .SEQ_LEN(SEQ_LEN)) sum_to_norm  ();
    row_bus_if #(.DATA_WIDTH(DATA_WIDTH), .SEQ_LEN(SEQ_LEN)) norm_to_seq  ();

    softmax_sequencer #(
        .DATA_WIDTH (DATA_WIDTH),
        .SEQ_LEN    (SEQ_LEN),
        .NUM_HEADS  (NUM_HEADS)
    ) u_sequencer (
        .clk         (clk),
        .rst_n       (rst_n),
        .start       (start),
        .scores_in   (scores_in),
        .weights_out (weights_out),
        .done        (done),
        .out_valid   (out_valid),
        .issue       (seq_to_relu.src),
        .collect     (norm_to_seq.dst)
    );

    // ------------------------------
    // Three-stage row pipeline
    // ------------------------------
    relu_stage #(.DATA_WIDTH(DATA_WIDTH), .SEQ_LEN(SEQ_LEN)) u_relu (
        .clk   (clk),
        .rst_n (rst_n),
        .up    (seq_to_relu.dst),
        .down  (relu_to_sum.src)
    );

    row_sum_stage #(.DATA_WIDTH(DATA_WIDTH), .SEQ_LEN(SEQ_LEN)) u_row_sum (
        .clk   (clk),
        .rst_n (rst_n),
        .up    (relu_to_sum.dst),
        .down  (sum_to_norm.src)
    );

    normalize_stage #(.DATA_WIDTH(DATA_WIDTH), .SEQ_LEN(SEQ_LEN)) u_normalize (
        .clk   (clk),
        .rst_n (rst_n),
        .up    (sum_to_norm.dst),
        .down  (norm_to_seq.src)
    );

endmodule

/* hw/softmax_pkg.sv */
// Shared sizes, fixed-point shift and sequencer states for the softmax pipeline RTL
package softmax_pkg;

    // ------------------------------
    // Default sizes
    // ------------------------------

    // Element width of scores and weights
    parameter int DEF_DATA_WIDTH = 16;

    // Sequence length, also the number of elements per row
    parameter int DEF_SEQ_LEN = 8;

    // Attention heads
    parameter int DEF_NUM_HEADS = 1;

    // Width of the row number carried with each row (up to 65536 rows)
    parameter int ROW_IDX_WIDTH = 16;

    // ------------------------------
    // Fixed point
    // ------------------------------

    // ReLU value is scaled by 2**FRAC_SHIFT before the divide
    parameter int FRAC_SHIFT = 4;

    // ------------------------------
    // Sequencer states
    // ------------------------------

    typedef enum logic [1:0] {
        SEQ_IDLE  = 2'd0,
        SEQ_ISSUE = 2'd1,
        SEQ_DRAIN = 2'd2,
        SEQ_DONE  = 2'd3
    } seq_state_t;

endpackage

/* hw/softmax_sequencer.sv */
// Issues matrix rows into the softmax pipeline, gathers normalized rows and pulses done
`timescale 1ns/100ps

module softmax_sequencer #(
    parameter int DATA_WIDTH = softmax_pkg::DEF_DATA_WIDTH,
    parameter int SEQ_LEN    = softmax_pkg::DEF_SEQ_LEN,
    parameter int NUM_HEADS  = softmax_pkg::DEF_NUM_HEADS
)(
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  start,
    input  logic [DATA_WIDTH-1:0] scores_in   [SEQ_LEN*NUM_HEADS*SEQ_LEN-1:0],
    output logic [DATA_WIDTH-1:0] weights_out [SEQ_LEN*NUM_HEADS*SEQ_LEN-1:0],
    output logic                  done,
    output logic                  out_valid,
    row_bus_if.src                issue,
    row_bus_if.dst                collect
);

    localparam int ROWS  = SEQ_LEN * NUM_HEADS;
    localparam int IDX_W = softmax_pkg::ROW_IDX_WIDTH;
    localparam logic [IDX_W-1:0] LAST_ROW = IDX_W'(ROWS - 1);

    softmax_pkg::seq_state_t state;

    logic [IDX_W-1:0] issue_cnt;
    logic [IDX_W-1:0] collect_cnt;
    logic             finish_pulse;

    // ------------------------------
    // FSM and counters
    // ------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state       <= softmax_pkg::SEQ_IDLE;
            issue_cnt   <= '0;
            collect_cnt <= '0;
            issue.valid <= 1'b0;
        end else begin
            issue.valid <= 1'b0;
            // Rows come back while issuing is still going on
            if (collect.valid) begin
                collect_cnt <= collect_cnt + 1'b1;
            end
            case (state)
                softmax_pkg::SEQ_IDLE: begin
                    if (start) begin
                        state       <= softmax_pkg::SEQ_ISSUE;
                        issue_cnt   <= '0;
                        collect_cnt <= '0;
                    end
                end
                softmax_pkg::SEQ_ISSUE: begin
                    issue.valid <= 1'b1;
                    if (issue_cnt == LAST_ROW) begin
                        state <= softmax_pkg::SEQ_DRAIN;
                    end else begin
                        issue_cnt <= issue_cnt + 1'b1;
                    end
                end
                softmax_pkg::SEQ_DRAIN: begin
                    if (collect.valid && collect_cnt == LAST_ROW) begin
                        state <= softmax_pkg::SEQ_DONE;
                    end
                end
                default: begin
                    state <= softmax_pkg::SEQ_IDLE;
                end
            endcase
        end
    end

    // Row payload sliced from the flat matrix
    always_ff @(posedge clk) begin
        if (state == softmax_pkg::SEQ_ISSUE) begin
            issue.row_idx <= issue_cnt;
            for (int j = 0; j < SEQ_LEN; j++) begin
                issue.elems[j] <= scores_in[int'(issue_cnt) * SEQ_LEN + j];
            end
        end
    end

    // No sum exists before the sum stage
    assign issue.row_sum = '0;

    // ------------------------------
    // Result collection
    // ------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < ROWS * SEQ_LEN; i++) begin
                weights_out[i] <= '0;
            end
            finish_pulse <= 1'b0;
        end else begin
            if (collect.valid) begin
                for (int j = 0; j < SEQ_LEN; j++) begin
                    weights_out[int'(collect.row_idx) * SEQ_LEN + j] <= collect.elems[j];
                end
            end
            finish_pulse <= (state == softmax_pkg::SEQ_DONE);
        end
    end

    assign done      = finish_pulse;
    assign out_valid = finish_pulse;

    // done comes one cycle after SEQ_DONE and no row arrives behind the last one
    a_done_after_done_state: assert property (@(posedge clk) disable iff (!rst_n)
        done |-> $past(state) == softmax_pkg::SEQ_DONE && !$past(collect.valid));

    // Pipeline must be empty whenever the FSM is idle
    a_no_collect_in_idle: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(collect.valid) |-> state != softmax_pkg::SEQ_IDLE);

endmodule

/* project.f */
hw/softmax_pkg.sv
hw/row_bus_if.sv
hw/relu_stage.sv
hw/row_sum_stage.sv
hw/normalize_stage.sv
hw/softmax_sequencer.sv
hw/softmax_approx_top.sv
verification/softmax_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build the softmax testbench with Verilator and run it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module softmax_tb -Mdir obj_dir -f project.f

output=$(./obj_dir/Vsoftmax_tb)
echo "$output"

if echo "$output" | grep -q "^sim passed$"; then
    exit 0
else
    exit 1
fi

/* verification/softmax_tb.sv */
// Simulation top that checks the softmax DUT on random and directed matrices against a model
`timescale 1ns/100ps

module softmax_tb;

    localparam int DATA_WIDTH      = softmax_pkg::DEF_DATA_WIDTH;
    localparam int SEQ_LEN         = softmax_pkg::DEF_SEQ_LEN;
    localparam int NUM_HEADS       = softmax_pkg::DEF_NUM_HEADS;
    localparam int ROWS            = SEQ_LEN * NUM_HEADS;
    localparam int NUM_ELEMS       = ROWS * SEQ_LEN;
    localparam int LATENCY         = ROWS + 5;
    localparam int NUM_RUNS        = 26;
    localparam int WATCHDOG_CYCLES = NUM_RUNS * (ROWS + 10) + 100;

    logic                  clk;
    logic                  rst_n;
    logic                  start;
    logic [DATA_WIDTH-1:0] scores_in   [NUM_ELEMS-1:0];
    logic [DATA_WIDTH-1:0] weights_out [NUM_ELEMS-1:0];
    logic                  done;
    logic                  out_valid;

    // Next matrix to apply and its model result
    logic [DATA_WIDTH-1:0] stim     [NUM_ELEMS-1:0];
    logic [DATA_WIDTH-1:0] expected [NUM_ELEMS-1:0];
    integer                seed;
    int                    test_errors;
    int                    total_errors;
    int                    tests_run;
    int                    tests_failed;

    softmax_approx_top #(
        .DATA_WIDTH (DATA_WIDTH),
        .SEQ_LEN    (SEQ_LEN),
        .NUM_HEADS  (NUM_HEADS)
    ) dut0 (
        .clk         (clk),
        .rst_n       (rst_n),
        .start       (start),
        .scores_in   (scores_in),
        .weights_out (weights_out),
        .done        (done),
        .out_valid   (out_valid)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    initial begin : watchdog
        #(WATCHDOG_CYCLES * 10);
        $display("Timeout: no result after %0d clock cycles, the run was stopped", WATCHDOG_CYCLES);
        $display("sim failed");
        $finish;
    end

    // ------------------------------
    // Checks
    // ------------------------------
    task automatic check_weight(input int idx, input logic [DATA_WIDTH-1:0] exp_val,
                                input logic [DATA_WIDTH-1:0] act_val);
        if (act_val !== exp_val) begin
            $display("ERR %0t: weight[%0d] expected %0d, got %0d", $time, idx, exp_val, act_val);
            test_errors++;
        end
    endtask

    task automatic check_done_timing(input int measured);
        if (measured != LATENCY) begin
            $display("ERR %0t: done after %0d cycles, expected %0d", $time, measured, LATENCY);
            test_errors++;
        end
    endtask

    task automatic check_flag(input string name, input logic exp_val, input logic act_val);
        if (act_val !== exp_val) begin
            $display("ERR %0t: %s expected %0b, got %0b", $time, name, exp_val, act_val);
            test_errors++;
        end
    endtask

    // ------------------------------
    // Model and stimulus
    // ------------------------------

    // ReLU and row sum, then scaled value over sum or zero when the sum is zero
    task automatic build_expected();
        int sum;
        int relu_val [SEQ_LEN];
        for (int r = 0; r < ROWS; r++) begin
            sum = 0;
            for (int j = 0; j < SEQ_LEN; j++) begin
                if (stim[r*SEQ_LEN+j][DATA_WIDTH-1]) begin
                    relu_val[j] = 0;
                end else begin
                    relu_val[j] = int'(stim[r*SEQ_LEN+j]);
                end
                sum += relu_val[j];
            end
            for (int j = 0; j < SEQ_LEN; j++) begin
                if (sum == 0) begin
                    expected[r*SEQ_LEN+j] = '0;
                end else begin
                    expected[r*SEQ_LEN+j] =
                        DATA_WIDTH'((relu_val[j] << softmax_pkg::FRAC_SHIFT) / sum);
                end
            end
        end
    endtask

    task automatic fill_random();
        for (int i = 0; i < NUM_ELEMS; i++) begin
            stim[i] = DATA_WIDTH'($random(seed));
        end
    endtask

    // Start is sampled by the DUT on the second edge
    task automatic apply_matrix();
        @(posedge clk);
        for (int i = 0; i < NUM_ELEMS; i++) begin
            scores_in[i] <= stim[i];
        end
        start <= 1'b1;
        @(posedge clk);
        start <= 1'b0;
    endtask

    task automatic idle_check(input int cycles);
        repeat (cycles) begin
            @(negedge clk);
            check_flag("done", 1'b0, done);
            check_flag("out_valid", 1'b0, out_valid);
        end
    endtask

    // Full run with an optional second start pulse three cycles in
    task automatic run_and_check(input bit extra_start);
        int cycles;
        bit seen;
        cycles = 0;
        seen   = 1'b0;
        build_expected();
        apply_matrix();
        while (!seen && cycles < LATENCY + 20) begin
            @(posedge clk);
            cycles++;
            start <= (extra_start && cycles == 3);
            @(negedge clk);
            check_flag("out_valid", cycles == LATENCY, out_valid);
            seen = done;
        end
        if (!seen) begin
            $display("No done pulse came within %0d cycles of start", cycles);
            test_errors++;
        end else begin
            check_done_timing(cycles);
            @(negedge clk);
            check_flag("done width", 1'b0, done);
            check_flag("out_valid width", 1'b0, out_valid);
            for (int i = 0; i < NUM_ELEMS; i++) begin
                check_weight(i, expected[i], weights_out[i]);
            end
        end
    endtask

    task automatic finish_test(input string name);
        tests_run++;
        total_errors += test_errors;
        if (test_errors == 0) begin
            $display("test %s: PASS", name);
        end else begin
            tests_failed++;
            $display("test %s: FAIL, %0d errors", name, test_errors);
        end
        test_errors = 0;
    endtask

    // ------------------------------
    // Test sequence
    // ------------------------------
    initial begin
        seed         = 32'h976d_b088;
        test_errors  = 0;
        total_errors = 0;
        tests_run    = 0;
        tests_failed = 0;
        rst_n <= 1'b0;
        start <= 1'b0;
        for (int i = 0; i < NUM_ELEMS; i++) begin
            scores_in[i] <= '0;
        end
        repeat (2) @(posedge clk);
        rst_n <= 1'b1;

        repeat (20) begin
            fill_random();
            run_and_check(1'b0);
        end
        finish_test("random_matrices");

        // Row 0 holds only negative and zero scores and row 1 a single positive one
        fill_random();
        for (int j = 0; j < SEQ_LEN; j++) begin
            stim[j] = (j % 2 == 0) ? '0 : (stim[j] | {1'b1, {(DATA_WIDTH-1){1'b0}}});
            stim[SEQ_LEN+j] = (j % 2 == 0) ? '0 : (stim[j] | {1'b1, {(DATA_WIDTH-1){1'b0}}});
        end
        stim[SEQ_LEN+3] = DATA_WIDTH'(1234);
        run_and_check(1'b0);
        for (int j = 0; j < SEQ_LEN; j++) begin
            check_weight(j, '0, weights_out[j]);
            check_weight(SEQ_LEN + j, (j == 3) ? DATA_WIDTH'(16) : '0, weights_out[SEQ_LEN+j]);
        end
        finish_test("directed_rows");

        @(posedge clk);
        rst_n <= 1'b0;
        idle_check(2);
        @(posedge clk);
        rst_n <= 1'b1;
        idle_check(3);
        fill_random();
        run_and_check(1'b0);
        finish_test("done_timing");

        fill_random();
        run_and_check(1'b1);
        idle_check(12);
        finish_test("restart_ignored");

        // Abort a run with reset once a few rows are written
        fill_random();
        apply_matrix();
        repeat (6) @(posedge clk);
        rst_n <= 1'b0;
        repeat (2) @(posedge clk);
        @(negedge clk);
        check_flag("done", 1'b0, done);
        for (int i = 0; i < NUM_ELEMS; i++) begin
            check_weight(i, '0, weights_out[i]);
        end
        @(posedge clk);
        rst_n <= 1'b1;
        idle_check(LATENCY);
        fill_random();
        run_and_check(1'b0);
        finish_test("reset_mid_run");

        $display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, total_errors);
        if (tests_failed == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule
